// File: all.f
hdl/idu_pkg.sv
hdl/idu_dec_if.sv
hdl/idu_decode.sv
hdl/idu_operand.sv
hdl/idu_dispatch.sv
hdl/idu_top.sv
tb/idu_checker.sv
tb/tb_idu.sv

// File: Bender.yml
package:
  name: idu

sources:
  - hdl/idu_pkg.sv
  - hdl/idu_dec_if.sv
  - hdl/idu_decode.sv
  - hdl/idu_operand.sv
  - hdl/idu_dispatch.sv
  - hdl/idu_top.sv
  - target: test
    files:
      - tb/idu_checker.sv
      - tb/tb_idu.sv

// File: tb/tb_idu.sv
`timescale 1ns/10ps

module tb_idu;
    import idu_pkg::*;

    localparam int n_instr  = 400;
    localparam int max_wait = 60;     // Cycles

    logic              IDUi_CLK;
    logic              IDUi_ARST;
    logic              flush;
    logic              in_valid;
    logic [xlen-1:0]   in_instr;
    logic [xlen-1:0]   in_pc;
    logic [priv_w-1:0] in_priv;
    logic              in_ready;
    logic [4:0]        gpr_rs1_index;
    logic              gpr_rs1_en;
    logic [4:0]        gpr_rs2_index;
    logic              gpr_rs2_en;
    logic [xlen-1:0]   rs1_data;
    logic [xlen-1:0]   rs2_data;
    logic              itag_write;
    logic [tag_w-1:0]  itag;
    logic [4:0]        itag_rd_index;
    logic              itag_rd_en;
    logic              alu_valid, lsu_valid;
    logic              alu_ready, lsu_ready;
    logic [xlen-1:0]   alu_pc, lsu_pc;
    logic [priv_w-1:0] alu_priv, lsu_priv;
    logic [tag_w-1:0]  alu_itag, lsu_itag;
    logic [op_w-1:0]   alu_op_code, lsu_op_code;
    logic [3:0]        alu_op_size, lsu_op_size;
    logic [1:0]        alu_op_info, lsu_op_info;
    logic [xlen-1:0]   alu_ds1, lsu_ds1;
    logic [xlen-1:0]   alu_ds2, lsu_ds2;
    logic [xlen-1:0]   regs [32];   // Register file model
    integer            seed;
    int                errors;
    int                timeouts;

    idu_top #(.TAG_SEED(8'h01)) dut0 (.*);

    idu_checker #(.TAG_SEED(8'h01)) chk0 (.*);

    assign rs1_data = regs[gpr_rs1_index];
    assign rs2_data = regs[gpr_rs2_index];

    initial begin
        IDUi_CLK = 1'b0;
        forever #20 IDUi_CLK = ~IDUi_CLK;
    end

    // Random fields, mostly the four handled classes
    function automatic logic [31:0] pick_instr();
        logic [31:0] w;
        int          kind;
        w    = $random(seed);
        kind = $random(seed) & 15;
        if (kind < 4) begin
            w[6:0] = opc_op;
        end else if (kind < 8) begin
            w[6:0] = opc_op_imm;
        end else if (kind < 11) begin
            w[6:0] = opc_load;
        end else if (kind < 14) begin
            w[6:0] = opc_store;
        end else begin
            w[6:0] = (kind == 14) ? 7'b1100011 : 7'b0110111;   // BRANCH or LUI
        end
        return w;
    endfunction

    task automatic drive_ready();
        alu_ready = $random(seed) & 1;
        lsu_ready = $random(seed) & 1;
    endtask

    ////////////////////
    // Input transfer
    ////////////////////
    task automatic send_instr(input logic [31:0] w);
        int   waited;
        logic other;
        other = (w[6:0] != opc_op) && (w[6:0] != opc_op_imm)
             && (w[6:0] != opc_load) && (w[6:0] != opc_store);
        @(negedge IDUi_CLK);
        if (($random(seed) & 7) == 0) begin
            in_valid = 1'b0;                // Idle gap
            flush    = 1'b0;
            @(negedge IDUi_CLK);
        end
        in_pc      = {$random(seed), $random(seed)};
        in_pc[1:0] = 2'b00;
        in_instr   = {$random(seed), $random(seed)};
        if (in_pc[2]) begin
            in_instr[xlen-1:32] = w;
        end else begin
            in_instr[31:0] = w;
        end
        in_priv  = $random(seed);
        in_valid = 1'b1;
        flush    = !other && (($random(seed) & 15) == 0);
        drive_ready();
        waited = 0;
        @(posedge IDUi_CLK);
        while (!in_ready) begin
            waited++;
            if (waited > max_wait) begin
                timeouts++;
                $display("Timeout: in_ready stayed low for %0d cycles", max_wait);
                break;
            end
            @(negedge IDUi_CLK);
            drive_ready();
            flush = other && (waited >= 3);     // Unknown opcode only leaves by flush
            @(posedge IDUi_CLK);
        end
    endtask

    task automatic drain_lanes();
        int waited;
        @(negedge IDUi_CLK);
        in_valid  = 1'b0;
        flush     = 1'b0;
        alu_ready = 1'b1;
        lsu_ready = 1'b1;
        waited    = 0;
        while (alu_valid || lsu_valid) begin
            waited++;
            if (waited > max_wait) begin
                timeouts++;
                $display("Timeout: lane outputs never drained");
                break;
            end
            @(negedge IDUi_CLK);
        end
    endtask

    initial begin
        seed      = 32'hd663_a484;
        timeouts  = 0;
        IDUi_ARST = 1'b1;
        flush     = 1'b0;
        in_valid  = 1'b0;
        in_instr  = '0;
        in_pc     = '0;
        in_priv   = '0;
        alu_ready = 1'b0;
        lsu_ready = 1'b0;
        for (int i = 0; i < 32; i++) begin
            regs[i] = {$random(seed), $random(seed)};
        end
        regs[0] = '0;
        repeat (4) @(posedge IDUi_CLK);
        @(negedge IDUi_CLK);
        IDUi_ARST = 1'b0;
        for (int n = 0; n < n_instr && timeouts == 0; n++) begin
            send_instr(pick_instr());
        end
        if (timeouts == 0) begin
            drain_lanes();
        end
        $display("Errors: %0d mismatches, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: tb/idu_checker.sv
`timescale 1ns/10ps

module idu_checker #(
    parameter logic [idu_pkg::tag_w-1:0] TAG_SEED = 'h01
) (
    input  logic                       IDUi_CLK,
    input  logic                       IDUi_ARST,
    input  logic                       flush,
    input  logic                       in_valid,
    input  logic [idu_pkg::xlen-1:0]   in_instr,
    input  logic [idu_pkg::xlen-1:0]   in_pc,
    input  logic [idu_pkg::priv_w-1:0] in_priv,
    input  logic                       in_ready,
    input  logic [4:0]                 gpr_rs1_index,
    input  logic                       gpr_rs1_en,
    input  logic [4:0]                 gpr_rs2_index,
    input  logic                       gpr_rs2_en,
    input  logic [idu_pkg::xlen-1:0]   rs1_data,
    input  logic [idu_pkg::xlen-1:0]   rs2_data,
    input  logic                       itag_write,
    input  logic [idu_pkg::tag_w-1:0]  itag,
    input  logic [4:0]                 itag_rd_index,
    input  logic                       itag_rd_en,
    input  logic                       alu_valid, lsu_valid,
    input  logic                       alu_ready, lsu_ready,
    input  logic [idu_pkg::xlen-1:0]   alu_pc, lsu_pc,
    input  logic [idu_pkg::priv_w-1:0] alu_priv, lsu_priv,
    input  logic [idu_pkg::tag_w-1:0]  alu_itag, lsu_itag,
    input  logic [idu_pkg::op_w-1:0]   alu_op_code, lsu_op_code,
    input  logic [3:0]                 alu_op_size, lsu_op_size,
    input  logic [1:0]                 alu_op_info, lsu_op_info,
    input  logic [idu_pkg::xlen-1:0]   alu_ds1, lsu_ds1,
    input  logic [idu_pkg::xlen-1:0]   alu_ds2, lsu_ds2,
    output int                         errors
);
    import idu_pkg::*;

    // Expected lane registers with ALU at index 0 and LSU at 1
    logic              m_v    [2];
    logic [xlen-1:0]   m_pc   [2];
    logic [priv_w-1:0] m_priv [2];
    logic [tag_w-1:0]  m_tag  [2];
    logic [op_w-1:0]   m_code [2];
    logic [3:0]        m_size [2];
    logic [1:0]        m_info [2];
    logic [xlen-1:0]   m_ds1  [2];
    logic [xlen-1:0]   m_ds2  [2];
    logic [tag_w-1:0]  tag;             // Model LFSR

    initial errors = 0;

    task automatic check_val(input string name, input logic [xlen-1:0] got,
                             input logic [xlen-1:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    // Expected decode of one instruction word from the ISA field rules
    task automatic model_decode(
        input  logic [31:0]     w,
        output int              lane,
        output logic [op_w-1:0] code,
        output logic [3:0]      size,
        output logic [1:0]      info,
        output logic [xlen-1:0] d1,
        output logic [xlen-1:0] d2,
        output logic            wr,
        output logic            use_rs2
    );
        logic [xlen-1:0] imm_i;
        logic [xlen-1:0] imm_s;
        imm_i   = {{(xlen-12){w[31]}}, w[31:20]};
        imm_s   = {{(xlen-12){w[31]}}, w[31:25], w[11:7]};
        lane    = 0;
        code    = {5'd0, w[14:12]};
        size    = 4'd8;
        info    = 2'd0;
        d1      = rs1_data;
        d2      = '0;
        wr      = 1'b0;
        use_rs2 = 1'b0;
        case (w[6:0])
            opc_op: begin
                lane    = 1;
                code[3] = w[30];            // funct7 bit 5
                d2      = rs2_data;
                wr      = 1'b1;
                use_rs2 = 1'b1;
            end
            opc_op_imm: begin
                lane    = 1;
                code[4] = 1'b1;
                code[3] = (w[14:12] == 3'b101) && w[30];
                d2      = imm_i;
                wr      = 1'b1;
            end
            opc_load: begin
                lane    = 2;
                size    = 4'd1 << w[13:12];
                info[0] = w[14];            // Unsigned load
                d1      = rs1_data + imm_i;
                wr      = 1'b1;
            end
            opc_store: begin
                lane    = 2;
                code[4] = 1'b1;
                size    = 4'd1 << w[13:12];
                info[0] = w[14];
                d1      = rs1_data + imm_s;
                d2      = rs2_data;
                use_rs2 = 1'b1;
            end
            default: begin
                lane = 0;
            end
        endcase
    endtask

    task automatic check_lane(
        input string             ln,
        input int                k,
        input logic              v,
        input logic [xlen-1:0]   pc,
        input logic [priv_w-1:0] priv,
        input logic [tag_w-1:0]  tg,
        input logic [op_w-1:0]   code,
        input logic [3:0]        size,
        input logic [1:0]        info,
        input logic [xlen-1:0]   d1,
        input logic [xlen-1:0]   d2
    );
        check_val({ln, "_valid"}, v, m_v[k]);
        if (m_v[k]) begin
            check_val({ln, "_pc"}, pc, m_pc[k]);
            check_val({ln, "_priv"}, priv, m_priv[k]);
            check_val({ln, "_itag"}, tg, m_tag[k]);
            check_val({ln, "_op_code"}, code, m_code[k]);
            check_val({ln, "_op_size"}, size, m_size[k]);
            check_val({ln, "_op_info"}, info, m_info[k]);
            check_val({ln, "_ds1"}, d1, m_ds1[k]);
            check_val({ln, "_ds2"}, d2, m_ds2[k]);
        end
    endtask

    ////////////////////
    // Per-edge compare
    ////////////////////
    always @(posedge IDUi_CLK) begin
        logic [31:0]     w;
        int              lane;
        logic [op_w-1:0] code;
        logic [3:0]      size;
        logic [1:0]      info;
        logic [xlen-1:0] d1;
        logic [xlen-1:0] d2;
        logic            wr;
        logic            use_rs2;
        logic            exp_rdy;
        logic            acc;
        logic            rdy;
        if (IDUi_ARST) begin
            tag    = TAG_SEED;
            m_v[0] = 1'b0;
            m_v[1] = 1'b0;
        end else begin
            w = in_pc[2] ? in_instr[xlen-1:32] : in_instr[31:0];
            model_decode(w, lane, code, size, info, d1, d2, wr, use_rs2);
            exp_rdy = in_valid && (flush || (lane == 1 && (!m_v[0] || alu_ready))
                                         || (lane == 2 && (!m_v[1] || lsu_ready)));
            acc     = exp_rdy && !flush;
            check_val("in_ready", in_ready, exp_rdy);
            check_val("itag", itag, tag);
            check_val("itag_write", itag_write, acc);
            if (acc) begin
                check_val("itag_rd_index", itag_rd_index, w[11:7]);
                check_val("itag_rd_en", itag_rd_en, wr && (w[11:7] != 5'd0));
            end
            if (in_valid) begin
                check_val("gpr_rs1_en", gpr_rs1_en, lane != 0);
                check_val("gpr_rs2_en", gpr_rs2_en, use_rs2);
                if (lane != 0) begin
                    check_val("gpr_rs1_index", gpr_rs1_index, w[19:15]);
                end
                if (use_rs2) begin
                    check_val("gpr_rs2_index", gpr_rs2_index, w[24:20]);
                end
            end
            check_lane("alu", 0, alu_valid, alu_pc, alu_priv, alu_itag, alu_op_code,
                       alu_op_size, alu_op_info, alu_ds1, alu_ds2);
            check_lane("lsu", 1, lsu_valid, lsu_pc, lsu_priv, lsu_itag, lsu_op_code,
                       lsu_op_size, lsu_op_info, lsu_ds1, lsu_ds2);
            for (int k = 0; k < 2; k++) begin
                rdy = (k == 0) ? alu_ready : lsu_ready;
                if (acc && lane == k + 1) begin
                    m_v[k]    = 1'b1;
                    m_pc[k]   = in_pc;
                    m_priv[k] = in_priv;
                    m_tag[k]  = tag;
                    m_code[k] = code;
                    m_size[k] = size;
                    m_info[k] = info;
                    m_ds1[k]  = d1;
                    m_ds2[k]  = d2;
                end else if (rdy) begin
                    m_v[k] = 1'b0;          // Taken downstream
                end
            end
            if (acc) begin
                tag = {tag[tag_w-2:0], ^(tag & 8'hb8)};     // Feedback from bits 7 5 4 3
            end
        end
    end

endmodule

// File: hdl/idu_top.sv
`timescale 1ns/10ps

module idu_top #(
    parameter logic [idu_pkg::tag_w-1:0] TAG_SEED = 'h01
) (
    input  logic                       IDUi_CLK,
    input  logic                       IDUi_ARST,
    input  logic                       flush,
    // Fetch input
    input  logic                       in_valid,
    input  logic [idu_pkg::xlen-1:0]   in_instr,
    input  logic [idu_pkg::xlen-1:0]   in_pc,
    input  logic [idu_pkg::priv_w-1:0] in_priv,
    output logic                       in_ready,
    // Register file reads
    output logic [4:0]                 gpr_rs1_index,
    output logic                       gpr_rs1_en,
    output logic [4:0]                 gpr_rs2_index,
    output logic                       gpr_rs2_en,
    input  logic [idu_pkg::xlen-1:0]   rs1_data,
    input  logic [idu_pkg::xlen-1:0]   rs2_data,
    // Tag table write
    output logic                       itag_write,
    output logic [idu_pkg::tag_w-1:0]  itag,
    output logic [4:0]                 itag_rd_index,
    output logic                       itag_rd_en,
    // ALU lane
    output logic                       alu_valid,
    output logic [idu_pkg::xlen-1:0]   alu_pc,
    output logic [idu_pkg::priv_w-1:0] alu_priv,
    output logic [idu_pkg::tag_w-1:0]  alu_itag,
    output logic [idu_pkg::op_w-1:0]   alu_op_code,
    output logic [3:0]                 alu_op_size,
    output logic [1:0]                 alu_op_info,
    output logic [idu_pkg::xlen-1:0]   alu_ds1,
    output logic [idu_pkg::xlen-1:0]   alu_ds2,
    input  logic                       alu_ready,
    // LSU lane
    output logic                       lsu_valid,
    output logic [idu_pkg::xlen-1:0]   lsu_pc,
    output logic [idu_pkg::priv_w-1:0] lsu_priv,
    output logic [idu_pkg::tag_w-1:0]  lsu_itag,
    output logic [idu_pkg::op_w-1:0]   lsu_op_code,
    output logic [3:0]                 lsu_op_size,
    output logic [1:0]                 lsu_op_info,
    output logic [idu_pkg::xlen-1:0]   lsu_ds1,
    output logic [idu_pkg::xlen-1:0]   lsu_ds2,
    input  logic                       lsu_ready
);

    logic [idu_pkg::xlen-1:0] ds1;
    logic [idu_pkg::xlen-1:0] ds2;

    idu_dec_if dec_bus ();

    idu_decode u_decode (
        .in_instr (in_instr),
        .in_pc    (in_pc),
        .dec      (dec_bus.dec)
    );

    idu_operand u_operand (
        .in_instr      (in_instr),
        .in_pc         (in_pc),
        .gpr_rs1_index (gpr_rs1_index),
        .gpr_rs1_en    (gpr_rs1_en),
        .gpr_rs2_index (gpr_rs2_index),
        .gpr_rs2_en    (gpr_rs2_en),
        .rs1_data      (rs1_data),
        .rs2_data      (rs2_data),
        .ds1           (ds1),
        .ds2           (ds2)
    );

    idu_dispatch #(
        .TAG_SEED (TAG_SEED)
    ) u_dispatch (
        .IDUi_CLK      (IDUi_CLK),
        .IDUi_ARST     (IDUi_ARST),
        .flush         (flush),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .in_pc         (in_pc),
        .in_priv       (in_priv),
        .dec           (dec_bus.disp),
        .ds1           (ds1),
        .ds2           (ds2),
        .itag_write    (itag_write),
        .itag          (itag),
        .itag_rd_index (itag_rd_index),
        .itag_rd_en    (itag_rd_en),
        .alu_valid     (alu_valid),
        .alu_pc        (alu_pc),
        .alu_priv      (alu_priv),
        .alu_itag      (alu_itag),
        .alu_op_code   (alu_op_code),
        .alu_op_size   (alu_op_size),
        .alu_op_info   (alu_op_info),
        .alu_ds1       (alu_ds1),
        .alu_ds2       (alu_ds2),
        .alu_ready     (alu_ready),
        .lsu_valid     (lsu_valid),
        .lsu_pc        (lsu_pc),
        .lsu_priv      (lsu_priv),
        .lsu_itag      (lsu_itag),
        .lsu_op_code   (lsu_op_code),
        .lsu_op_size   (lsu_op_size),
        .lsu_op_info   (lsu_op_info),
        .lsu_ds1       (lsu_ds1),
        .lsu_ds2       (lsu_ds2),
        .lsu_ready     (lsu_ready)
    );

endmodule

// File: hdl/idu_dispatch.sv
`timescale 1ns/10ps

module idu_dispatch #(
    parameter logic [idu_pkg::tag_w-1:0] TAG_SEED = 'h01
) (
    input  logic                       IDUi_CLK,
    input  logic                       IDUi_ARST,
    input  logic                       flush,
    input  logic                       in_valid,
    output logic                       in_ready,
    input  logic [idu_pkg::xlen-1:0]   in_pc,
    input  logic [idu_pkg::priv_w-1:0] in_priv,
    idu_dec_if.disp                    dec,
    input  logic [idu_pkg::xlen-1:0]   ds1,
    input  logic [idu_pkg::xlen-1:0]   ds2,
    // Tag table write
    output logic                       itag_write,
    output logic [idu_pkg::tag_w-1:0]  itag,
    output logic [4:0]                 itag_rd_index,
    output logic                       itag_rd_en,
    // ALU lane
    output logic                       alu_valid,
    output logic [idu_pkg::xlen-1:0]   alu_pc,
    output logic [idu_pkg::priv_w-1:0] alu_priv,
    output logic [idu_pkg::tag_w-1:0]  alu_itag,
    output logic [idu_pkg::op_w-1:0]   alu_op_code,
    output logic [3:0]                 alu_op_size,
    output logic [1:0]                 alu_op_info,
    output logic [idu_pkg::xlen-1:0]   alu_ds1,
    output logic [idu_pkg::xlen-1:0]   alu_ds2,
    input  logic                       alu_ready,
    // LSU lane
    output logic                       lsu_valid,
    output logic [idu_pkg::xlen-1:0]   lsu_pc,
    output logic [idu_pkg::priv_w-1:0] lsu_priv,
    output logic [idu_pkg::tag_w-1:0]  lsu_itag,
    output logic [idu_pkg::op_w-1:0]   lsu_op_code,
    output logic [3:0]                 lsu_op_size,
    output logic [1:0]                 lsu_op_info,
    output logic [idu_pkg::xlen-1:0]   lsu_ds1,
    output logic [idu_pkg::xlen-1:0]   lsu_ds2,
    input  logic                       lsu_ready
);
    import idu_pkg::*;

    logic             alu_can_load;
    logic             lsu_can_load;
    logic             accept;
    logic             alu_load;
    logic             lsu_load;
    logic [tag_w-1:0] tag_q;

    // A lane takes a new item when empty or draining this cycle
    assign alu_can_load = ~alu_valid | alu_ready;
    assign lsu_can_load = ~lsu_valid | lsu_ready;

    // Flush swallows whatever is waiting at the input
    assign in_ready = in_valid & (flush | (dec.alu_sel & alu_can_load)
                                        | (dec.lsu_sel & lsu_can_load));
    assign accept   = in_valid & in_ready & ~flush;
    assign alu_load = accept & dec.alu_sel;
    assign lsu_load = accept & dec.lsu_sel;

    // Tag LFSR, taps 8 6 5 4
    always_ff @(posedge IDUi_CLK or posedge IDUi_ARST) begin
        if (IDUi_ARST) begin
            tag_q <= TAG_SEED;
        end else if (accept) begin
            tag_q <= {tag_q[tag_w-2:0], tag_q[7] ^ tag_q[5] ^ tag_q[4] ^ tag_q[3]};
        end
    end

    assign itag          = tag_q;
    assign itag_write    = accept;
    assign itag_rd_index = dec.rd_index;
    assign itag_rd_en    = dec.rd_en;

    ////////////////////
    // ALU lane
    ////////////////////
    always_ff @(posedge IDUi_CLK or posedge IDUi_ARST) begin
        if (IDUi_ARST) begin
            alu_valid <= 1'b0;
        end else if (alu_load) begin
            alu_valid <= 1'b1;
        end else if (alu_ready) begin
            alu_valid <= 1'b0;                  // Consumed downstream
        end
    end

    always_ff @(posedge IDUi_CLK) begin
        if (alu_load) begin                     // Held otherwise
            alu_pc      <= in_pc;
            alu_priv    <= in_priv;
            alu_itag    <= tag_q;
            alu_op_code <= dec.op_code;
            alu_op_size <= dec.op_size;
            alu_op_info <= dec.op_info;
            alu_ds1     <= ds1;
            alu_ds2     <= ds2;
        end
    end

    ////////////////////
    // LSU lane
    ////////////////////
    always_ff @(posedge IDUi_CLK or posedge IDUi_ARST) begin
        if (IDUi_ARST) begin
            lsu_valid <= 1'b0;
        end else if (lsu_load) begin
            lsu_valid <= 1'b1;
        end else if (lsu_ready) begin
            lsu_valid <= 1'b0;
        end
    end

    always_ff @(posedge IDUi_CLK) begin
        if (lsu_load) begin
            lsu_pc      <= in_pc;
            lsu_priv    <= in_priv;
            lsu_itag    <= tag_q;
            lsu_op_code <= dec.op_code;
            lsu_op_size <= dec.op_size;
            lsu_op_info <= dec.op_info;
            lsu_ds1     <= ds1;                 // Address
            lsu_ds2     <= ds2;                 // Store data
        end
    end

endmodule

// File: hdl/idu_operand.sv
`timescale 1ns/10ps

module idu_operand (
    input  logic [idu_pkg::xlen-1:0] in_instr,
    input  logic [idu_pkg::xlen-1:0] in_pc,
    output logic [4:0]               gpr_rs1_index,
    output logic                     gpr_rs1_en,
    output logic [4:0]               gpr_rs2_index,
    output logic                     gpr_rs2_en,
    input  logic [idu_pkg::xlen-1:0] rs1_data,
    input  logic [idu_pkg::xlen-1:0] rs2_data,
    output logic [idu_pkg::xlen-1:0] ds1,
    output logic [idu_pkg::xlen-1:0] ds2
);
    import idu_pkg::*;

    instr_u          instr;
    logic            is_op;
    logic            is_op_imm;
    logic            is_load;
    logic            is_store;
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_s;
    logic [xlen-1:0] addr;

    assign instr = in_pc[2] ? in_instr[xlen-1:32] : in_instr[31:0];

    assign is_op     = (instr.f.opcode == opc_op);
    assign is_op_imm = (instr.f.opcode == opc_op_imm);
    assign is_load   = (instr.f.opcode == opc_load);
    assign is_store  = (instr.f.opcode == opc_store);

    // Register file read requests
    assign gpr_rs1_index = instr.f.rs1;
    assign gpr_rs1_en    = is_op | is_op_imm | is_load | is_store;
    assign gpr_rs2_index = instr.f.rs2;
    assign gpr_rs2_en    = is_op | is_store;

    // Sign-extended immediates, bit 31 is the sign in both forms
    assign imm_i = {{(xlen-12){instr.i.imm_s_hi[6]}}, instr.i.imm_s_hi, instr.i.imm_i_lo};
    assign imm_s = {{(xlen-12){instr.i.imm_s_hi[6]}}, instr.i.imm_s_hi, instr.i.imm_s_lo};

    assign addr = rs1_data + (is_store ? imm_s : imm_i);    // Effective address

    always_comb begin
        ds1 = rs1_data;
        ds2 = '0;
        if (is_op) begin
            ds2 = rs2_data;
        end else if (is_op_imm) begin
            ds2 = imm_i;
        end else if (is_load) begin
            ds1 = addr;
        end else if (is_store) begin
            ds1 = addr;
            ds2 = rs2_data;                                 // Store data
        end
    end

endmodule

// File: hdl/idu_decode.sv
`timescale 1ns/10ps

module idu_decode (
    input  logic [idu_pkg::xlen-1:0] in_instr,
    input  logic [idu_pkg::xlen-1:0] in_pc,
    idu_dec_if.dec                   dec
);
    import idu_pkg::*;

    instr_u          instr;
    logic [1:0]      lane;
    logic [op_w-1:0] op_code;
    logic [3:0]      op_size;
    logic [1:0]      op_info;
    logic            wr_rd;

    // Upper half holds the instruction when pc[2] is set
    assign instr = in_pc[2] ? in_instr[xlen-1:32] : in_instr[31:0];

    always_comb begin
        lane    = lane_none;
        op_code = '0;
        op_size = 4'd0;
        op_info = 2'b00;
        wr_rd   = 1'b0;
        case (instr.f.opcode)
            opc_op: begin
                lane                = lane_alu;
                op_code[2:0]        = instr.f.funct3;
                op_code[op_bit_sub] = instr.f.funct7[5];
                op_size             = 4'd8;
                wr_rd               = 1'b1;
            end
            opc_op_imm: begin
                lane                = lane_alu;
                op_code[2:0]        = instr.f.funct3;
                op_code[op_bit_imm] = 1'b1;
                // Only SRAI carries the arithmetic flag
                op_code[op_bit_sub] = (instr.f.funct3 == 3'b101) & instr.f.funct7[5];
                op_size             = 4'd8;
                wr_rd               = 1'b1;
            end
            opc_load: begin
                lane         = lane_lsu;
                op_code[2:0] = instr.f.funct3;
                op_size      = 4'd1 << instr.f.funct3[1:0];
                op_info[0]   = instr.f.funct3[2];       // LBU / LHU / LWU
                wr_rd        = 1'b1;
            end
            opc_store: begin
                lane                  = lane_lsu;
                op_code[2:0]          = instr.f.funct3;
                op_code[op_bit_store] = 1'b1;
                op_size               = 4'd1 << instr.f.funct3[1:0];
                op_info[0]            = instr.f.funct3[2];
            end
            default: begin
                lane = lane_none;                       // Waits for flush
            end
        endcase
    end

    assign dec.alu_sel  = (lane == lane_alu);
    assign dec.lsu_sel  = (lane == lane_lsu);
    assign dec.op_code  = op_code;
    assign dec.op_size  = op_size;
    assign dec.op_info  = op_info;
    assign dec.rd_index = instr.f.rd;
    assign dec.rd_en    = wr_rd & (instr.f.rd != 5'd0);     // x0 never written

endmodule

// File: hdl/idu_dec_if.sv
`timescale 1ns/10ps

interface idu_dec_if;
    import idu_pkg::*;

    logic            alu_sel;
    logic            lsu_sel;
    logic [op_w-1:0] op_code;
    logic [3:0]      op_size;       // Byte count
    logic [1:0]      op_info;
    logic [4:0]      rd_index;
    logic            rd_en;

    modport dec (
        output alu_sel, lsu_sel, op_code, op_size, op_info, rd_index, rd_en
    );

    modport disp (
        input alu_sel, lsu_sel, op_code, op_size, op_info, rd_index, rd_en
    );

endinterface

// File: hdl/idu_pkg.sv
package idu_pkg;

    localparam int xlen   = 64;
    localparam int tag_w  = 8;
    localparam int op_w   = 8;
    localparam int priv_w = 2;

    // Major opcodes handled here
    localparam logic [6:0] opc_load   = 7'b0000011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_store  = 7'b0100011;
    localparam logic [6:0] opc_op     = 7'b0110011;

    // Target lane of a decoded instruction
    localparam logic [1:0] lane_none = 2'd0;
    localparam logic [1:0] lane_alu  = 2'd1;
    localparam logic [1:0] lane_lsu  = 2'd2;

    // Flag bits inside the dispatch op code
    localparam int op_bit_sub   = 3;        // ALU arithmetic / subtract
    localparam int op_bit_imm   = 4;        // ALU immediate form
    localparam int op_bit_store = 4;        // LSU store

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } instr_fields_t;

    // I imm is {imm_s_hi, imm_i_lo}, S imm is {imm_s_hi, imm_s_lo}
    typedef struct packed {
        logic [6:0] imm_s_hi;
        logic [4:0] imm_i_lo;
        logic [7:0] rsv;
        logic [4:0] imm_s_lo;
        logic [6:0] opc;
    } instr_imm_t;

    typedef union packed {
        instr_fields_t f;
        instr_imm_t    i;
    } instr_u;

endpackage
